//--- cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Datapath word width
`define DATA_WIDTH 32

// Register file size and address width
`define REG_COUNT 8
`define REG_ADDR_WIDTH 3

// Data memory, word addressed
`define DMEM_DEPTH 16
`define DMEM_ADDR_WIDTH 4

`endif

//--- cpu_pkg.sv
`default_nettype none

`include "cpu_macros.svh"

package cpu_pkg;

    // Instruction opcodes, NOP is all zeros so a cleared register is a bubble
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_ADDI = 4'd6,
        OP_LW   = 4'd7,
        OP_SW   = 4'd8
    } opcode_e;

    // Where a stage's result comes from
    // Only ALU results are ready while still in execute
    typedef enum logic [1:0] {
        SRC_NONE = 2'd0,
        SRC_ALU  = 2'd1,
        SRC_MEM  = 2'd2
    } exec_src_e;

    // Pre-fetched instruction fields
    typedef struct packed {
        opcode_e                    op;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        logic [15:0]                imm;
    } instr_t;

endpackage

`default_nettype wire

//--- stage_fwd_if.sv
`default_nettype none

`include "cpu_macros.svh"

// Write-back request of one stage, fed back to decode for bypassing
interface stage_fwd_if;
    import cpu_pkg::*;

    // Stage holds an instruction that writes a register
    logic                       wb_reg;
    // Origin of the result value
    exec_src_e                  exec_src;
    // Destination register
    logic [`REG_ADDR_WIDTH-1:0] write_addr;
    // Result value
    logic [`DATA_WIDTH-1:0]     write;

    // Driven by the pipeline stage
    modport source (
        output wb_reg,
        output exec_src,
        output write_addr,
        output write
    );

    // Read by decode
    modport sink (
        input wb_reg,
        input exec_src,
        input write_addr,
        input write
    );

endinterface

`default_nettype wire

//--- register_file.sv
`default_nettype none

`include "cpu_macros.svh"

module register_file (
    input  wire                       clk,
    input  wire                       rst,
    input  wire [`REG_ADDR_WIDTH-1:0] rs_addr,
    input  wire [`REG_ADDR_WIDTH-1:0] rt_addr,
    output logic [`DATA_WIDTH-1:0]    rs_data,
    output logic [`DATA_WIDTH-1:0]    rt_data,
    input  wire                       write_enable,
    input  wire [`REG_ADDR_WIDTH-1:0] write_addr,
    input  wire [`DATA_WIDTH-1:0]     write
);

    // Register storage, no special register 0
    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    // Asynchronous read ports
    // Same-cycle write is covered by write-back forwarding in decode
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

    // Single write port
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (write_enable)
        begin
            regs[write_addr] <= write;
        end
    end

endmodule

`default_nettype wire

//--- forwarding_unit.sv
`default_nettype none

`include "cpu_macros.svh"

module forwarding_unit (
    // Operand requests from decode
    input  wire                       dec_rs_enable,
    input  wire [`REG_ADDR_WIDTH-1:0] dec_prs_addr,
    input  wire [`DATA_WIDTH-1:0]     dec_rs_data,
    input  wire                       dec_rt_enable,
    input  wire [`REG_ADDR_WIDTH-1:0] dec_prt_addr,
    input  wire [`DATA_WIDTH-1:0]     dec_rt_data,
    // Results still in flight
    stage_fwd_if.sink                 exec_fwd,
    stage_fwd_if.sink                 mem_fwd,
    stage_fwd_if.sink                 wb_fwd,
    // Operands after bypassing
    output logic [`DATA_WIDTH-1:0]    dec_rs_override,
    output logic [`DATA_WIDTH-1:0]    dec_rt_override
);
    import cpu_pkg::*;

    ////////////////////////////////////////////////////////////
    // Operand selection
    ////////////////////////////////////////////////////////////

    // Youngest producer wins: execute, then memory, then write back
    function automatic logic [`DATA_WIDTH-1:0] pick_operand(
        input logic                       enable,
        input logic [`REG_ADDR_WIDTH-1:0] addr,
        input logic [`DATA_WIDTH-1:0]     reg_value
    );
        logic [`DATA_WIDTH-1:0] value;
        // Default is the register file copy
        value = reg_value;
        if (enable)
        begin
            // Loads in execute have no data yet, stall handles them
            if (exec_fwd.wb_reg && exec_fwd.exec_src == SRC_ALU &&
                exec_fwd.write_addr == addr)
                value = exec_fwd.write;
            else if (mem_fwd.wb_reg && mem_fwd.write_addr == addr)
                value = mem_fwd.write;
            else if (wb_fwd.wb_reg && wb_fwd.write_addr == addr)
                value = wb_fwd.write;
        end
        return value;
    endfunction

    // Same rule for both operands
    always_comb
    begin
        dec_rs_override = pick_operand(dec_rs_enable, dec_prs_addr, dec_rs_data);
        dec_rt_override = pick_operand(dec_rt_enable, dec_prt_addr, dec_rt_data);
    end

endmodule

`default_nettype wire

//--- decode_stage.sv
`default_nettype none

`include "cpu_macros.svh"

module decode_stage (
    input  wire                        clk,
    input  wire                        rst,
    // Instruction input
    input  wire                        instr_valid,
    input  wire cpu_pkg::instr_t       instr,
    output logic                       stall,
    // Bypass sources
    stage_fwd_if.sink                  exec_fwd,
    stage_fwd_if.sink                  mem_fwd,
    stage_fwd_if.sink                  wb_fwd,
    // Register file read ports
    output logic [`REG_ADDR_WIDTH-1:0] rs_addr,
    output logic [`REG_ADDR_WIDTH-1:0] rt_addr,
    input  wire [`DATA_WIDTH-1:0]      rs_data,
    input  wire [`DATA_WIDTH-1:0]      rt_data,
    // Execute pipeline register
    output cpu_pkg::instr_t            ex_instr,
    output logic                       ex_valid,
    output logic [`DATA_WIDTH-1:0]     ex_rs_value,
    output logic [`DATA_WIDTH-1:0]     ex_rt_value
);
    import cpu_pkg::*;

    logic                   rs_enable;
    logic                   rt_enable;
    logic [`DATA_WIDTH-1:0] rs_value;
    logic [`DATA_WIDTH-1:0] rt_value;
    logic                   load_use;

    ////////////////////////////////////////////////////////////
    // Operand usage and register reads
    ////////////////////////////////////////////////////////////

    assign rs_addr = instr.rs;
    assign rt_addr = instr.rt;

    // rs for every real op, rt for reg-reg ops and store data
    always_comb
    begin
        rs_enable = (instr.op != OP_NOP);
        case (instr.op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SW: rt_enable = 1'b1;
            default:                                       rt_enable = 1'b0;
        endcase
    end

    forwarding_unit u_forwarding_unit (
        .dec_rs_enable   (rs_enable),
        .dec_prs_addr    (instr.rs),
        .dec_rs_data     (rs_data),
        .dec_rt_enable   (rt_enable),
        .dec_prt_addr    (instr.rt),
        .dec_rt_data     (rt_data),
        .exec_fwd        (exec_fwd),
        .mem_fwd         (mem_fwd),
        .wb_fwd          (wb_fwd),
        .dec_rs_override (rs_value),
        .dec_rt_override (rt_value)
    );

    ////////////////////////////////////////////////////////////
    // Load-use hazard
    ////////////////////////////////////////////////////////////

    // Load in execute whose destination is read here
    assign load_use = exec_fwd.wb_reg && exec_fwd.exec_src == SRC_MEM &&
                      ((rs_enable && instr.rs == exec_fwd.write_addr) ||
                       (rt_enable && instr.rt == exec_fwd.write_addr));

    assign stall = instr_valid && load_use;

    // Execute register, bubble when idle or stalled
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ex_valid <= 1'b0;
            ex_instr <= '0;
        end
        else if (instr_valid && !stall)
        begin
            ex_valid <= 1'b1;
            ex_instr <= instr;
        end
        else
        begin
            ex_valid    <= 1'b0;
            ex_instr.op <= OP_NOP;
        end
    end

    // Operand payload, only meaningful alongside ex_valid
    always_ff @(posedge clk)
    begin
        ex_rs_value <= rs_value;
        ex_rt_value <= rt_value;
    end

endmodule

`default_nettype wire

//--- execute_stage.sv
`default_nettype none

`include "cpu_macros.svh"

module execute_stage (
    input  wire                        clk,
    input  wire                        rst,
    // From the decode pipeline register
    input  wire cpu_pkg::instr_t       ex_instr,
    input  wire                        ex_valid,
    input  wire [`DATA_WIDTH-1:0]      ex_rs_value,
    input  wire [`DATA_WIDTH-1:0]      ex_rt_value,
    // Bypass request back to decode
    stage_fwd_if.source                exec_fwd,
    // Memory pipeline register
    output cpu_pkg::opcode_e           mem_op,
    output logic [`REG_ADDR_WIDTH-1:0] mem_rd,
    output logic [`DATA_WIDTH-1:0]     mem_result,
    output logic [`DATA_WIDTH-1:0]     mem_store_data,
    output logic                       mem_valid
);
    import cpu_pkg::*;

    logic [`DATA_WIDTH-1:0] imm_ext;
    logic [`DATA_WIDTH-1:0] result;

    // Sign-extended immediate
    assign imm_ext = {{(`DATA_WIDTH-16){ex_instr.imm[15]}}, ex_instr.imm};

    ////////////////////////////////////////////////////////////
    // ALU and result source
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        result            = '0;
        exec_fwd.exec_src = SRC_NONE;
        case (ex_instr.op)
            OP_ADD:  result = ex_rs_value + ex_rt_value;
            OP_SUB:  result = ex_rs_value - ex_rt_value;
            OP_AND:  result = ex_rs_value & ex_rt_value;
            OP_OR:   result = ex_rs_value | ex_rt_value;
            OP_XOR:  result = ex_rs_value ^ ex_rt_value;
            // Immediate add, also the load/store address
            OP_ADDI, OP_LW, OP_SW: result = ex_rs_value + imm_ext;
            default: result = '0;
        endcase
        case (ex_instr.op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI: exec_fwd.exec_src = SRC_ALU;
            // Load data arrives in memory stage
            OP_LW:   exec_fwd.exec_src = SRC_MEM;
            default: exec_fwd.exec_src = SRC_NONE;
        endcase
    end

    // Stores and NOPs leave the register file alone
    assign exec_fwd.wb_reg     = ex_valid && (exec_fwd.exec_src != SRC_NONE);
    assign exec_fwd.write_addr = ex_instr.rd;
    assign exec_fwd.write      = result;

    // Control part of the memory register
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mem_valid <= 1'b0;
            mem_op    <= OP_NOP;
        end
        else
        begin
            mem_valid <= ex_valid;
            mem_op    <= ex_instr.op;
        end
    end

    // Payload part
    always_ff @(posedge clk)
    begin
        mem_rd         <= ex_instr.rd;
        mem_result     <= result;
        mem_store_data <= ex_rt_value;
    end

endmodule

`default_nettype wire

//--- memory_stage.sv
`default_nettype none

`include "cpu_macros.svh"

module memory_stage (
    input  wire                       clk,
    input  wire                       rst,
    // From the execute pipeline register
    input  wire cpu_pkg::opcode_e     mem_op,
    input  wire [`REG_ADDR_WIDTH-1:0] mem_rd,
    input  wire [`DATA_WIDTH-1:0]     mem_result,
    input  wire [`DATA_WIDTH-1:0]     mem_store_data,
    input  wire                       mem_valid,
    // Bypass requests of memory and write back
    stage_fwd_if.source               mem_fwd,
    stage_fwd_if.source               wb_fwd
);
    import cpu_pkg::*;

    logic [`DATA_WIDTH-1:0]     dmem [`DMEM_DEPTH];
    logic [`DMEM_ADDR_WIDTH-1:0] dmem_addr;
    logic                       mem_wb_reg;
    exec_src_e                  mem_src;
    logic [`DATA_WIDTH-1:0]     mem_write;
    logic                       wb_valid_q;
    exec_src_e                  wb_src_q;
    logic [`REG_ADDR_WIDTH-1:0] wb_rd_q;
    logic [`DATA_WIDTH-1:0]     wb_data_q;

    ////////////////////////////////////////////////////////////
    // Data memory
    ////////////////////////////////////////////////////////////

    // Word address from the low bits of the ALU sum
    assign dmem_addr = mem_result[`DMEM_ADDR_WIDTH-1:0];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `DMEM_DEPTH; i++)
            begin
                dmem[i] <= '0;
            end
        end
        else if (mem_valid && mem_op == OP_SW)
        begin
            dmem[dmem_addr] <= mem_store_data;
        end
    end

    // Result of this stage, load data read asynchronously
    always_comb
    begin
        case (mem_op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI: mem_src = SRC_ALU;
            OP_LW:   mem_src = SRC_MEM;
            default: mem_src = SRC_NONE;
        endcase
        mem_write = (mem_op == OP_LW) ? dmem[dmem_addr] : mem_result;
    end

    assign mem_wb_reg = mem_valid && (mem_src != SRC_NONE);

    assign mem_fwd.wb_reg     = mem_wb_reg;
    assign mem_fwd.exec_src   = mem_src;
    assign mem_fwd.write_addr = mem_rd;
    assign mem_fwd.write      = mem_write;

    ////////////////////////////////////////////////////////////
    // Write-back register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wb_valid_q <= 1'b0;
            wb_src_q   <= SRC_NONE;
        end
        else
        begin
            wb_valid_q <= mem_wb_reg;
            wb_src_q   <= mem_src;
        end
    end

    always_ff @(posedge clk)
    begin
        wb_rd_q   <= mem_rd;
        wb_data_q <= mem_write;
    end

    // Also feeds the register file write port
    assign wb_fwd.wb_reg     = wb_valid_q;
    assign wb_fwd.exec_src   = wb_src_q;
    assign wb_fwd.write_addr = wb_rd_q;
    assign wb_fwd.write      = wb_data_q;

endmodule

`default_nettype wire

//--- pipeline_top.sv
`default_nettype none

`include "cpu_macros.svh"

module pipeline_top (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        instr_valid,
    input  wire cpu_pkg::instr_t       instr,
    output logic                       stall,
    output logic                       wb_valid,
    output logic [`REG_ADDR_WIDTH-1:0] wb_addr,
    output logic [`DATA_WIDTH-1:0]     wb_data
);
    import cpu_pkg::*;

    // Register file read path
    logic [`REG_ADDR_WIDTH-1:0] rs_addr;
    logic [`REG_ADDR_WIDTH-1:0] rt_addr;
    logic [`DATA_WIDTH-1:0]     rs_data;
    logic [`DATA_WIDTH-1:0]     rt_data;

    // Decode to execute
    instr_t                     ex_instr;
    logic                       ex_valid;
    logic [`DATA_WIDTH-1:0]     ex_rs_value;
    logic [`DATA_WIDTH-1:0]     ex_rt_value;

    // Execute to memory
    opcode_e                    mem_op;
    logic [`REG_ADDR_WIDTH-1:0] mem_rd;
    logic [`DATA_WIDTH-1:0]     mem_result;
    logic [`DATA_WIDTH-1:0]     mem_store_data;
    logic                       mem_valid;

    // Bypass paths back into decode
    stage_fwd_if exec_fwd ();
    stage_fwd_if mem_fwd ();
    stage_fwd_if wb_fwd ();

    decode_stage u_decode (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .stall       (stall),
        .exec_fwd    (exec_fwd),
        .mem_fwd     (mem_fwd),
        .wb_fwd      (wb_fwd),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .ex_instr    (ex_instr),
        .ex_valid    (ex_valid),
        .ex_rs_value (ex_rs_value),
        .ex_rt_value (ex_rt_value)
    );

    execute_stage u_execute (
        .clk            (clk),
        .rst            (rst),
        .ex_instr       (ex_instr),
        .ex_valid       (ex_valid),
        .ex_rs_value    (ex_rs_value),
        .ex_rt_value    (ex_rt_value),
        .exec_fwd       (exec_fwd),
        .mem_op         (mem_op),
        .mem_rd         (mem_rd),
        .mem_result     (mem_result),
        .mem_store_data (mem_store_data),
        .mem_valid      (mem_valid)
    );

    memory_stage u_memory (
        .clk            (clk),
        .rst            (rst),
        .mem_op         (mem_op),
        .mem_rd         (mem_rd),
        .mem_result     (mem_result),
        .mem_store_data (mem_store_data),
        .mem_valid      (mem_valid),
        .mem_fwd        (mem_fwd),
        .wb_fwd         (wb_fwd)
    );

    // Written from the write-back register
    register_file u_register_file (
        .clk          (clk),
        .rst          (rst),
        .rs_addr      (rs_addr),
        .rt_addr      (rt_addr),
        .rs_data      (rs_data),
        .rt_data      (rt_data),
        .write_enable (wb_fwd.wb_reg),
        .write_addr   (wb_fwd.write_addr),
        .write        (wb_fwd.write)
    );

    // Writeback observation
    assign wb_valid = wb_fwd.wb_reg;
    assign wb_addr  = wb_fwd.write_addr;
    assign wb_data  = wb_fwd.write;

endmodule

`default_nettype wire

//--- tb_pipeline.sv
`default_nettype none

`include "cpu_macros.svh"

module tb_pipeline;
    import cpu_pkg::*;

    localparam int RANDOM_COUNT = 300;

    logic                       clk;
    logic                       rst;
    logic                       instr_valid;
    instr_t                     instr;
    logic                       stall;
    logic                       wb_valid;
    logic [`REG_ADDR_WIDTH-1:0] wb_addr;
    logic [`DATA_WIDTH-1:0]     wb_data;

    // Architectural model state
    logic [`DATA_WIDTH-1:0]     model_regs [`REG_COUNT];
    logic [`DATA_WIDTH-1:0]     model_mem [`DMEM_DEPTH];

    // Expected writebacks in issue order
    logic [`REG_ADDR_WIDTH-1:0] exp_addr [$];
    logic [`DATA_WIDTH-1:0]     exp_data [$];
    int                         exp_cycle [$];

    // Program to issue and the idle cycles before each entry
    instr_t                     program_q [$];
    int                         gap_q [$];

    int cycle = 0;
    int limit = 0;
    int errors = 0;
    int checked = 0;

    pipeline_top dut (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .stall       (stall),
        .wb_valid    (wb_valid),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Cycle count read on falling edges
    always @(posedge clk)
    begin
        cycle <= cycle + 1;
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic instr_t make_instr(input opcode_e op, input logic [2:0] rd,
                                          input logic [2:0] rs, input logic [2:0] rt,
                                          input logic [15:0] imm);
        instr_t i;
        i.op  = op;
        i.rd  = rd;
        i.rs  = rs;
        i.rt  = rt;
        i.imm = imm;
        return i;
    endfunction

    // Register-register ops and stores read rt
    function automatic bit reads_rt(input opcode_e op);
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SW: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic bit writes_reg(input opcode_e op);
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LW: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Load directly followed by a reader of its destination
    function automatic bit is_load_use(input instr_t older, input instr_t younger);
        if (older.op != OP_LW || younger.op == OP_NOP)
            return 1'b0;
        return (younger.rs == older.rd) || (reads_rt(younger.op) && younger.rt == older.rd);
    endfunction

    // Result value or the word address for a store
    function automatic logic [`DATA_WIDTH-1:0] ref_result(input instr_t i);
        logic [`DATA_WIDTH-1:0] a;
        logic [`DATA_WIDTH-1:0] b;
        logic [`DATA_WIDTH-1:0] sum;
        a   = model_regs[i.rs];
        b   = model_regs[i.rt];
        sum = a + {{(`DATA_WIDTH-16){i.imm[15]}}, i.imm};
        case (i.op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_ADDI: return sum;
            OP_LW:   return model_mem[sum[`DMEM_ADDR_WIDTH-1:0]];
            OP_SW:   return sum;
            default: return '0;
        endcase
    endfunction

    // Retire one accepted instruction into the model
    task automatic model_execute(input instr_t i, input int accept_cycle);
        logic [`DATA_WIDTH-1:0] res;
        res = ref_result(i);
        if (i.op == OP_SW)
            model_mem[res[`DMEM_ADDR_WIDTH-1:0]] = model_regs[i.rt];
        else if (writes_reg(i.op))
        begin
            model_regs[i.rd] = res;
            exp_addr.push_back(i.rd);
            exp_data.push_back(res);
            exp_cycle.push_back(accept_cycle + 3);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Driver
    ////////////////////////////////////////////////////////////

    task automatic queue_instr(input instr_t i, input int gap);
        program_q.push_back(i);
        gap_q.push_back(gap);
    endtask

    task automatic idle(input int n);
        instr_valid <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    // Hold the instruction until a rising edge without stall
    task automatic send_instr(input instr_t i, input bit expect_stall);
        int stalls;
        int accept_cycle;
        bit accepted;
        stalls   = 0;
        accepted = 1'b0;
        instr       <= i;
        instr_valid <= 1'b1;
        while (!accepted)
        begin
            @(negedge clk);
            if (stall)
                stalls++;
            else
            begin
                accepted     = 1'b1;
                accept_cycle = cycle;
            end
            @(posedge clk);
        end
        assert (stalls == (expect_stall ? 1 : 0))
        else
        begin
            errors++;
            $display("ERROR: stall cycles got %h expected %h", stalls, expect_stall);
        end
        model_execute(i, accept_cycle);
    endtask

    ////////////////////////////////////////////////////////////
    // Writeback checker
    ////////////////////////////////////////////////////////////

    always @(negedge clk)
    begin
        if (!rst && wb_valid)
        begin
            assert (exp_addr.size() != 0)
            else
            begin
                errors++;
                $display("Writeback to register %0d arrived with none expected", wb_addr);
            end
            if (exp_addr.size() != 0)
            begin
                checked++;
                assert (wb_addr == exp_addr[0])
                else
                begin
                    errors++;
                    $display("ERROR: wb_addr got %h expected %h", wb_addr, exp_addr[0]);
                end
                assert (wb_data == exp_data[0])
                else
                begin
                    errors++;
                    $display("ERROR: wb_data got %h expected %h", wb_data, exp_data[0]);
                end
                // Three cycles from acceptance to wb_valid
                assert (cycle == exp_cycle[0])
                else
                begin
                    errors++;
                    $display("ERROR: wb_valid cycle got %h expected %h", cycle, exp_cycle[0]);
                end
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
                void'(exp_cycle.pop_front());
            end
        end
    end

    // Guards against a stuck stall or lost writebacks
    initial
    begin
        wait (limit > 0);
        while (cycle < limit)
            @(posedge clk);
        $display("Run stopped after %0d cycles without finishing, errors: %0d", limit, errors);
        $display("Done: errors found");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial
    begin
        instr_t prev;
        bit     prev_adjacent;
        int     drain;
        int     imm_val;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        prev        = '0;
        prev_adjacent = 1'b0;
        for (int r = 0; r < `REG_COUNT; r++)
            model_regs[r] = '0;
        for (int m = 0; m < `DMEM_DEPTH; m++)
            model_mem[m] = '0;
        void'($urandom(32'ha92c6e8f));

        // Independent ALU ops and ADDI
        queue_instr(make_instr(OP_ADDI, 1, 0, 0, 16'd5), 0);
        queue_instr(make_instr(OP_ADDI, 2, 0, 0, 16'hfffd), 0);
        queue_instr(make_instr(OP_ADDI, 3, 0, 0, 16'd100), 0);
        queue_instr(make_instr(OP_ADD, 4, 1, 2, 16'd0), 3);
        queue_instr(make_instr(OP_SUB, 5, 3, 1, 16'd0), 0);
        queue_instr(make_instr(OP_AND, 6, 3, 2, 16'd0), 0);
        queue_instr(make_instr(OP_OR, 7, 1, 3, 16'd0), 0);
        queue_instr(make_instr(OP_XOR, 0, 2, 3, 16'd0), 0);
        // Bypass at distance 1, 2 and 3
        queue_instr(make_instr(OP_ADDI, 1, 0, 0, 16'd7), 3);
        queue_instr(make_instr(OP_ADD, 2, 1, 1, 16'd0), 0);
        queue_instr(make_instr(OP_ADDI, 3, 0, 0, 16'd9), 0);
        queue_instr(make_instr(OP_NOP, 0, 0, 0, 16'd0), 0);
        queue_instr(make_instr(OP_SUB, 4, 3, 1, 16'd0), 0);
        queue_instr(make_instr(OP_ADDI, 5, 0, 0, 16'd11), 0);
        queue_instr(make_instr(OP_NOP, 0, 0, 0, 16'd0), 0);
        queue_instr(make_instr(OP_NOP, 0, 0, 0, 16'd0), 0);
        queue_instr(make_instr(OP_XOR, 6, 5, 3, 16'd0), 0);
        queue_instr(make_instr(OP_ADDI, 7, 0, 0, 16'd3), 0);
        queue_instr(make_instr(OP_OR, 0, 2, 7, 16'd0), 0);
        // Same destination in several stages
        queue_instr(make_instr(OP_ADDI, 2, 0, 0, 16'd1), 3);
        queue_instr(make_instr(OP_ADDI, 2, 0, 0, 16'd2), 0);
        queue_instr(make_instr(OP_ADDI, 2, 0, 0, 16'd3), 0);
        queue_instr(make_instr(OP_ADD, 3, 2, 2, 16'd0), 0);
        queue_instr(make_instr(OP_LW, 4, 0, 0, 16'd0), 0);
        queue_instr(make_instr(OP_ADDI, 4, 0, 0, 16'd5), 0);
        queue_instr(make_instr(OP_ADD, 5, 4, 4, 16'd0), 0);
        queue_instr(make_instr(OP_ADDI, 6, 0, 0, 16'd1), 0);
        queue_instr(make_instr(OP_LW, 6, 0, 0, 16'd1), 0);
        queue_instr(make_instr(OP_NOP, 0, 0, 0, 16'd0), 0);
        queue_instr(make_instr(OP_ADD, 1, 6, 6, 16'd0), 0);
        // Load-use with and without a gap
        // r7 cleared first as a zero base
        queue_instr(make_instr(OP_XOR, 7, 7, 7, 16'd0), 3);
        queue_instr(make_instr(OP_ADDI, 1, 7, 0, 16'h0055), 0);
        queue_instr(make_instr(OP_SW, 0, 7, 1, 16'd2), 0);
        queue_instr(make_instr(OP_LW, 2, 7, 0, 16'd2), 0);
        queue_instr(make_instr(OP_ADD, 3, 2, 2, 16'd0), 0);
        queue_instr(make_instr(OP_LW, 4, 7, 0, 16'd2), 0);
        queue_instr(make_instr(OP_NOP, 0, 0, 0, 16'd0), 0);
        queue_instr(make_instr(OP_ADD, 5, 4, 1, 16'd0), 0);
        queue_instr(make_instr(OP_LW, 6, 7, 0, 16'd2), 0);
        queue_instr(make_instr(OP_SW, 0, 7, 6, 16'd3), 0);
        // Store then load with bypassed store data and address
        queue_instr(make_instr(OP_ADDI, 1, 7, 0, 16'h1234), 0);
        queue_instr(make_instr(OP_SW, 0, 7, 1, 16'd5), 0);
        queue_instr(make_instr(OP_LW, 2, 7, 0, 16'd5), 0);
        queue_instr(make_instr(OP_ADDI, 6, 7, 0, 16'd3), 0);
        queue_instr(make_instr(OP_SW, 0, 6, 2, 16'd1), 0);
        queue_instr(make_instr(OP_LW, 3, 6, 0, 16'd1), 0);
        queue_instr(make_instr(OP_ADD, 4, 3, 2, 16'd0), 0);

        // Random mix with small signed immediates and rare idle gaps
        for (int k = 0; k < RANDOM_COUNT; k++)
        begin
            imm_val = int'($urandom_range(31)) - 16;
            queue_instr(make_instr(opcode_e'($urandom_range(8)), 3'($urandom_range(7)),
                                   3'($urandom_range(7)), 3'($urandom_range(7)),
                                   imm_val[15:0]),
                        ($urandom_range(7) == 0) ? int'($urandom_range(3, 1)) : 0);
        end
        limit = 20 * program_q.size() + 50;

        repeat (3) @(posedge clk);
        rst <= 1'b0;

        for (int k = 0; k < program_q.size(); k++)
        begin
            if (gap_q[k] > 0)
            begin
                idle(gap_q[k]);
                prev_adjacent = 1'b0;
            end
            send_instr(program_q[k], prev_adjacent && is_load_use(prev, program_q[k]));
            prev          = program_q[k];
            prev_adjacent = 1'b1;
        end

        // Let the pipeline empty
        instr_valid <= 1'b0;
        drain = 0;
        while (exp_addr.size() != 0 && drain < 10)
        begin
            @(posedge clk);
            drain++;
        end
        repeat (4) @(posedge clk);
        assert (exp_addr.size() == 0)
        else
        begin
            errors++;
            $display("Pipeline drained with %0d writebacks still missing", exp_addr.size());
        end

        $display("Writebacks checked: %0d, errors: %0d", checked, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
cpu_pkg.sv
stage_fwd_if.sv
register_file.sv
forwarding_unit.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
pipeline_top.sv
tb_pipeline.sv
